/* arcade_pkg.sv */
// Arcade I/O shared definitions: widths, joystick and key positions, scan codes, receiver states.
package arcade_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Joystick layout.
	localparam int JOY_BITS = 12; // Keyboard joystick vector.

	localparam int JOY_RIGHT = 0; // Board joystick bits.
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_START = 4;
	localparam int JOY_COIN  = 5;

	localparam int KB_P1_RIGHT = 0;
	localparam int KB_P1_LEFT  = 1;
	localparam int KB_P1_DOWN  = 2;
	localparam int KB_P1_UP    = 3;
	localparam int KB_START1   = 5;
	localparam int KB_START2   = 6;
	localparam int KB_COIN     = 7;
	localparam int KB_P2_RIGHT = 8;
	localparam int KB_P2_LEFT  = 9;
	localparam int KB_P2_DOWN  = 10;
	localparam int KB_P2_UP    = 11;

	// ~~~~~~~~~~~~~~~~~~~~
	// PS/2 set 2 scan codes.
	localparam logic [7:0] SC_RELEASE  = 8'hF0;
	localparam logic [7:0] SC_EXTENDED = 8'hE0;
	localparam logic [7:0] SC_UP       = 8'h75; // Arrows need the E0 prefix.
	localparam logic [7:0] SC_DOWN     = 8'h72;
	localparam logic [7:0] SC_LEFT     = 8'h6B;
	localparam logic [7:0] SC_RIGHT    = 8'h74;
	localparam logic [7:0] SC_W        = 8'h1D;
	localparam logic [7:0] SC_S        = 8'h1B;
	localparam logic [7:0] SC_A        = 8'h1C;
	localparam logic [7:0] SC_D        = 8'h23;
	localparam logic [7:0] SC_F1       = 8'h05;
	localparam logic [7:0] SC_F2       = 8'h06;
	localparam logic [7:0] SC_COIN     = 8'h2E; // Key "5".

	typedef enum logic [1:0] {PS2_IDLE, PS2_DATA, PS2_PARITY, PS2_STOP} ps2_state_e;

	// Active-low game inputs, coin1 in the top bit.
	typedef struct packed {
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
		logic up1;
		logic down1;
		logic left1;
		logic right1;
		logic up2;
		logic down2;
		logic left2;
		logic right2;
	} game_ctrl_t;

endpackage

/* kbd_event_if.sv */
// Key event link from the PS/2 receiver to the key mapper.
`timescale 1ns/100ps

interface kbd_event_if;

	logic       valid;    // One cycle strobe, no back-pressure.
	logic [7:0] code;     // Final byte of the key sequence.
	logic       released; // F0 seen before code.
	logic       extended; // E0 seen before code.

	modport sender (
		output valid,
		output code,
		output released,
		output extended
	);

	modport receiver (
		input valid,
		input code,
		input released,
		input extended
	);

endinterface

/* ps2_receiver.sv */
// PS/2 keyboard receiver: filters the clock, assembles frames and emits key events.
`timescale 1ns/100ps

module ps2_receiver import arcade_pkg::*; #(
	parameter int FILTER_LEN = 4
) (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           ps2_clk,
	input  logic           ps2_data,
	kbd_event_if.sender    ev,
	output logic           frame_error
);

	localparam int CNT_W = $clog2(FILTER_LEN + 1);

	logic [1:0]       clk_sync;
	logic [1:0]       data_sync;
	logic [CNT_W-1:0] filt_cnt;
	logic             clk_filt;
	logic             clk_prev;
	logic             fall;

	ps2_state_e       state;
	logic [2:0]       bit_cnt;
	logic [7:0]       shift_reg;
	logic             parity_bit;
	logic             stop_bit;
	logic             frame_done;
	logic             pend_rel;
	logic             pend_ext;
	logic             frame_ok;

	// ~~~~~~~~~~~~~~~~~~~~
	// Synchronizers and clock glitch filter.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			filt_cnt  <= '0;
			clk_filt  <= 1'b1;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_filt;
			if (clk_sync[1] == clk_filt)
				filt_cnt <= '0;
			else if (filt_cnt == CNT_W'(FILTER_LEN - 1)) begin
				clk_filt <= clk_sync[1]; // Stable long enough.
				filt_cnt <= '0;
			end else
				filt_cnt <= filt_cnt + 1'b1;
		end
	end

	assign fall = clk_prev & ~clk_filt;

	// ~~~~~~~~~~~~~~~~~~~~
	// Frame shifter.
	always_ff @(posedge clk_sys) begin
		frame_done <= 1'b0;
		if (reset) begin
			state   <= PS2_IDLE;
			bit_cnt <= '0;
		end else if (fall) begin
			case (state)
				PS2_IDLE: if (!data_sync[1]) begin // Start bit.
					state   <= PS2_DATA;
					bit_cnt <= '0;
				end
				PS2_DATA: begin
					shift_reg <= {data_sync[1], shift_reg[7:1]}; // LSB first.
					bit_cnt   <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7)
						state <= PS2_PARITY;
				end
				PS2_PARITY: begin
					parity_bit <= data_sync[1];
					state      <= PS2_STOP;
				end
				PS2_STOP: begin
					stop_bit   <= data_sync[1];
					frame_done <= 1'b1;
					state      <= PS2_IDLE;
				end
				default: state <= PS2_IDLE;
			endcase
		end
	end

	assign frame_ok = (^{parity_bit, shift_reg}) & stop_bit; // Odd parity.

	// Prefix tracking and event output, one cycle after the frame completes.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ev.valid    <= 1'b0;
			frame_error <= 1'b0;
			pend_rel    <= 1'b0;
			pend_ext    <= 1'b0;
		end else begin
			ev.valid    <= 1'b0;
			frame_error <= 1'b0;
			if (frame_done) begin
				if (!frame_ok) begin
					frame_error <= 1'b1;
					pend_rel    <= 1'b0;
					pend_ext    <= 1'b0;
				end else if (shift_reg == SC_RELEASE)
					pend_rel <= 1'b1;
				else if (shift_reg == SC_EXTENDED)
					pend_ext <= 1'b1;
				else begin
					ev.valid    <= 1'b1;
					ev.code     <= shift_reg;
					ev.released <= pend_rel;
					ev.extended <= pend_ext;
					pend_rel    <= 1'b0;
					pend_ext    <= 1'b0;
				end
			end
		end
	end

endmodule

/* key_mapper.sv */
// Key mapper: keeps the pressed state of each mapped key as a keyboard joystick vector.
`timescale 1ns/100ps

module key_mapper import arcade_pkg::*; (
	input  logic                clk_sys,
	input  logic                reset,
	kbd_event_if.receiver       ev,
	output logic [JOY_BITS-1:0] kbjoy
);

	logic [JOY_BITS-1:0] hit; // One-hot bit for the current code.

	// ~~~~~~~~~~~~~~~~~~~~
	// Scan code lookup.
	always_comb begin
		hit = '0;
		case (ev.code)
			SC_UP: begin
				if (ev.extended)
					hit[KB_P1_UP] = 1'b1;
			end
			SC_DOWN: begin
				if (ev.extended)
					hit[KB_P1_DOWN] = 1'b1;
			end
			SC_LEFT: begin
				if (ev.extended)
					hit[KB_P1_LEFT] = 1'b1;
			end
			SC_RIGHT: begin
				if (ev.extended)
					hit[KB_P1_RIGHT] = 1'b1;
			end
			SC_W:    hit[KB_P2_UP]    = 1'b1;
			SC_S:    hit[KB_P2_DOWN]  = 1'b1;
			SC_A:    hit[KB_P2_LEFT]  = 1'b1;
			SC_D:    hit[KB_P2_RIGHT] = 1'b1;
			SC_F1:   hit[KB_START1]   = 1'b1;
			SC_F2:   hit[KB_START2]   = 1'b1;
			SC_COIN: hit[KB_COIN]     = 1'b1;
			default: hit = '0; // Unmapped keys.
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Pressed state.
	always_ff @(posedge clk_sys) begin
		if (reset)
			kbjoy <= '0;
		else if (ev.valid) begin
			if (ev.released)
				kbjoy <= kbjoy & ~hit;
			else
				kbjoy <= kbjoy | hit;
		end
	end

endmodule

/* control_merge.sv */
// Control merger: combines keyboard, joysticks and status into registered game controls.
`timescale 1ns/100ps

module control_merge import arcade_pkg::*; (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic [JOY_BITS-1:0] kbjoy,
	input  logic [7:0]          joy0,
	input  logic [7:0]          joy1,
	input  logic [31:0]         status,
	input  logic [1:0]          buttons,
	input  logic                lamp1,
	input  logic                lamp2,
	output game_ctrl_t          game_ctrl,
	output logic                game_reset,
	output logic                self_test,
	output logic                led
);

	game_ctrl_t ctrl_next;

	// Inputs are active low on the game side.
	always_comb begin
		ctrl_next.coin1  = ~kbjoy[KB_COIN];
		ctrl_next.coin2  = ~kbjoy[KB_COIN];
		ctrl_next.start1 = ~(kbjoy[KB_START1] | joy0[JOY_START]);
		ctrl_next.start2 = ~(kbjoy[KB_START2] | joy1[JOY_START]);
		ctrl_next.up1    = ~(kbjoy[KB_P1_UP]    | joy0[JOY_UP]);
		ctrl_next.down1  = ~(kbjoy[KB_P1_DOWN]  | joy0[JOY_DOWN]);
		ctrl_next.left1  = ~(kbjoy[KB_P1_LEFT]  | joy0[JOY_LEFT]);
		ctrl_next.right1 = ~(kbjoy[KB_P1_RIGHT] | joy0[JOY_RIGHT]);
		ctrl_next.up2    = ~(kbjoy[KB_P2_UP]    | joy1[JOY_UP]);
		ctrl_next.down2  = ~(kbjoy[KB_P2_DOWN]  | joy1[JOY_DOWN]);
		ctrl_next.left2  = ~(kbjoy[KB_P2_LEFT]  | joy1[JOY_LEFT]);
		ctrl_next.right2 = ~(kbjoy[KB_P2_RIGHT] | joy1[JOY_RIGHT]);
	end

	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_ctrl  <= '1; // All released.
			game_reset <= 1'b1;
			self_test  <= 1'b0;
			led        <= 1'b1;
		end else begin
			game_ctrl  <= ctrl_next;
			game_reset <= status[0] | status[6] | buttons[1]; // Menu reset or button.
			self_test  <= status[1];
			led        <= ~(lamp1 | lamp2);
		end
	end

endmodule

/* sigma_delta_dac.sv */
// First-order delta-sigma DAC for the game audio sample.
`timescale 1ns/100ps

module sigma_delta_dac #(
	parameter int AUDIO_BITS = 7
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [AUDIO_BITS-1:0] audio,
	output logic                  dac_out
);

	logic [AUDIO_BITS:0] acc; // Top bit is the carry.

	// ~~~~~~~~~~~~~~~~~~~~
	// The carry leaves as the pulse and is dropped before the next sum.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= {1'b0, acc[AUDIO_BITS-1:0]} + {1'b0, audio};
			dac_out <= acc[AUDIO_BITS];
		end
	end

endmodule

/* mono_video_out.sv */
// Monochrome video stage: widens one-bit video to RGB with blanking and aligned syncs.
`timescale 1ns/100ps

module mono_video_out (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       video,
	input  logic       hs,
	input  logic       vs,
	input  logic       hb,
	input  logic       vb,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic [5:0] pixel;

	assign pixel = (hb | vb) ? 6'h00 : {6{video}}; // Black while blanking.

	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r  <= pixel;
			vga_g  <= pixel;
			vga_b  <= pixel;
			vga_hs <= hs; // Same stage as the colour.
			vga_vs <= vs;
		end
	end

endmodule

/* arcade_io_top.sv */
// Arcade I/O top level: keyboard and joystick controls, audio DAC and video output stage.
`timescale 1ns/100ps

module arcade_io_top import arcade_pkg::*; #(
	parameter int AUDIO_BITS = 7,
	parameter int FILTER_LEN = 4
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ps2_clk,
	input  logic                  ps2_data,
	input  logic [7:0]            joy0,
	input  logic [7:0]            joy1,
	input  logic [31:0]           status,
	input  logic [1:0]            buttons,
	input  logic                  lamp1,
	input  logic                  lamp2,
	input  logic [AUDIO_BITS-1:0] audio,
	input  logic                  video,
	input  logic                  hs,
	input  logic                  vs,
	input  logic                  hb,
	input  logic                  vb,
	output logic [11:0]           game_ctrl,
	output logic                  game_reset,
	output logic                  self_test,
	output logic                  led,
	output logic                  kbd_error,
	output logic                  audio_l,
	output logic                  audio_r,
	output logic [5:0]            vga_r,
	output logic [5:0]            vga_g,
	output logic [5:0]            vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs
);

	kbd_event_if         kbd_ev ();
	logic [JOY_BITS-1:0] kbjoy;
	game_ctrl_t          ctrl;
	logic                dac_out;

	// ~~~~~~~~~~~~~~~~~~~~
	// Input side.
	ps2_receiver #(.FILTER_LEN(FILTER_LEN)) ps2_rx (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.ev          (kbd_ev.sender),
		.frame_error (kbd_error)
	);

	key_mapper keymap (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ev      (kbd_ev.receiver),
		.kbjoy   (kbjoy)
	);

	control_merge ctrl_merge (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.kbjoy      (kbjoy),
		.joy0       (joy0),
		.joy1       (joy1),
		.status     (status),
		.buttons    (buttons),
		.lamp1      (lamp1),
		.lamp2      (lamp2),
		.game_ctrl  (ctrl),
		.game_reset (game_reset),
		.self_test  (self_test),
		.led        (led)
	);

	assign game_ctrl = ctrl;

	// ~~~~~~~~~~~~~~~~~~~~
	// Output side.
	sigma_delta_dac #(.AUDIO_BITS(AUDIO_BITS)) dac (
		.clk_sys (clk_sys),
		.reset   (reset),
		.audio   (audio),
		.dac_out (dac_out)
	);

	assign audio_l = dac_out; // Mono game, same stream on both channels.
	assign audio_r = dac_out;

	mono_video_out vid_out (
		.clk_sys (clk_sys),
		.reset   (reset),
		.video   (video),
		.hs      (hs),
		.vs      (vs),
		.hb      (hb),
		.vb      (vb),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset generator for the arcade I/O block.
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#10 reset = 1'b0; // Released like any other input.
	end

endmodule

/* tb_checker.sv */
// Testbench checker: watches the DUT outputs, compares them with expected values, counts rows.
`timescale 1ns/100ps

module tb_checker (
	input logic        clk,
	input logic        reset,
	input logic [11:0] game_ctrl,
	input logic        game_reset,
	input logic        self_test,
	input logic        led,
	input logic        kbd_error,
	input logic        audio_l,
	input logic        audio_r,
	input logic [5:0]  vga_r,
	input logic [5:0]  vga_g,
	input logic [5:0]  vga_b,
	input logic        vga_hs,
	input logic        vga_vs
);

	localparam int CTRL_TIMEOUT = 20; // Cycles.

	int row_errors  = 0;
	int rows_passed = 0;
	int rows_failed = 0;
	int err_pulses  = 0;
	int audio_mism  = 0;
	int audio_seen  = 0;

	// ~~~~~~~~~~~~~~~~~~~~
	// Continuous watch, sampled mid-cycle.
	always @(negedge clk) begin
		if (!reset) begin
			if (kbd_error)
				err_pulses++;
			if (audio_r !== audio_l) begin
				$display("Error audio_r expected %0h got %0h", audio_l, audio_r);
				audio_mism++;
			end
		end
	end

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got) begin
			$display("Error %s expected %0h got %0h", name, exp, got);
			row_errors++;
		end
	endtask

	task automatic expect_ctrl(input logic [11:0] exp, input logic [2:0] misc);
		int n;
		n = 0;
		while ((game_ctrl !== exp || {game_reset, self_test, led} !== misc)
				&& n < CTRL_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (game_ctrl !== exp || {game_reset, self_test, led} !== misc)
			$display("Game controls did not settle within %0d cycles", CTRL_TIMEOUT);
		compare("game_ctrl", exp, game_ctrl);
		compare("game_reset", misc[2], game_reset);
		compare("self_test", misc[1], self_test);
		compare("led", misc[0], led);
	endtask

	// Registered stage, so the result shows one cycle after the inputs.
	task automatic expect_video(input logic [7:0] exp);
		@(negedge clk);
		compare("vga_r", exp[7:2], vga_r);
		compare("vga_g", exp[7:2], vga_g);
		compare("vga_b", exp[7:2], vga_b);
		compare("vga_hs", exp[1], vga_hs);
		compare("vga_vs", exp[0], vga_vs);
	endtask

	task automatic count_audio(input int level);
		int ones;
		ones = 0;
		repeat (128) begin
			@(negedge clk);
			ones += audio_l;
		end
		compare("audio_l ones", level, ones);
	endtask

	task automatic expect_errors(input int exp);
		compare("kbd_error pulses", exp, err_pulses);
	endtask

	task automatic end_row(input int idx, input string what);
		int errs;
		errs       = row_errors + (audio_mism - audio_seen);
		audio_seen = audio_mism;
		row_errors = 0;
		if (errs == 0) begin
			rows_passed++;
			$display("row %0d %s ok", idx, what);
		end else begin
			rows_failed++;
			$display("row %0d %s failed with %0d errors", idx, what, errs);
		end
	endtask

	task automatic report();
		$display("%0d rows passed, %0d rows failed", rows_passed, rows_failed);
	endtask

endmodule

/* tb_arcade_io.sv */
// Testbench top for the arcade I/O block: stimulus table, PS/2 frame driver and apply loop.
`timescale 1ns/100ps

module tb_arcade_io import arcade_pkg::*; ();

	localparam int K_KEY   = 0;
	localparam int K_CTRL  = 1;
	localparam int K_AUDIO = 2;
	localparam int K_VIDEO = 3;

	typedef struct packed {
		int          kind;
		logic [23:0] seq;  // PS/2 bytes, first byte on top.
		int          n;
		bit          bad;  // Corrupt the parity of each byte.
		logic [27:0] stim; // {lamp2, lamp1, buttons, status[7:0], joy1, joy0}.
		logic [11:0] exp;
		logic [2:0]  misc; // {game_reset, self_test, led}.
	} row_t;

	row_t        rows[$];
	logic        clk, reset, ps2_clk, ps2_data, lamp1, lamp2, video, hs, vs, hb, vb;
	logic [7:0]  joy0, joy1;
	logic [31:0] status;
	logic [1:0]  buttons;
	logic [6:0]  audio;
	logic [11:0] game_ctrl;
	logic        game_reset, self_test, led, kbd_error, audio_l, audio_r, vga_hs, vga_vs;
	logic [5:0]  vga_r, vga_g, vga_b;

	tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(4)) clkgen (.clk(clk), .reset(reset));

	arcade_io_top #(.AUDIO_BITS(7), .FILTER_LEN(4)) dut0 (
		.clk_sys(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
		.joy0(joy0), .joy1(joy1), .status(status), .buttons(buttons),
		.lamp1(lamp1), .lamp2(lamp2), .audio(audio), .video(video),
		.hs(hs), .vs(vs), .hb(hb), .vb(vb), .game_ctrl(game_ctrl),
		.game_reset(game_reset), .self_test(self_test), .led(led), .kbd_error(kbd_error),
		.audio_l(audio_l), .audio_r(audio_r), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hs(vga_hs), .vga_vs(vga_vs)
	);

	tb_checker chk0 (
		.clk(clk), .reset(reset), .game_ctrl(game_ctrl), .game_reset(game_reset),
		.self_test(self_test), .led(led), .kbd_error(kbd_error), .audio_l(audio_l),
		.audio_r(audio_r), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hs(vga_hs), .vga_vs(vga_vs)
	);

	task automatic push_row(int kind, logic [23:0] seq, int n, bit bad, logic [27:0] stim,
			logic [11:0] exp, logic [2:0] misc);
		row_t r;
		r.kind = kind;
		r.seq  = seq;
		r.n    = n;
		r.bad  = bad;
		r.stim = stim;
		r.exp  = exp;
		r.misc = misc;
		rows.push_back(r);
	endtask

	task automatic key_row(logic [23:0] seq, int n, bit bad, logic [11:0] exp);
		push_row(K_KEY, seq, n, bad, '0, exp, 3'b001);
	endtask

	task automatic ctrl_row(logic [27:0] stim, logic [11:0] exp, logic [2:0] misc);
		push_row(K_CTRL, '0, 0, 0, stim, exp, misc);
	endtask

	// Ones per 128 cycles equal the level.
	task automatic audio_row(logic [6:0] level);
		push_row(K_AUDIO, '0, 0, 0, {21'h0, level}, {5'h0, level}, 3'b001);
	endtask

	task automatic video_row(logic [4:0] vin, logic [7:0] exp);
		push_row(K_VIDEO, '0, 0, 0, {23'h0, vin}, {4'h0, exp}, 3'b001);
	endtask

	task automatic hold(int cycles);
		repeat (cycles) @(posedge clk);
		#10;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// PS/2 device side, 40 us bit period, data changes while the clock is high.
	task automatic send_byte(logic [7:0] data, bit bad);
		logic [10:0] frame;
		frame = {1'b1, (~^data) ^ bad, data, 1'b0}; // Stop, odd parity, data, start.
		for (int i = 0; i < 11; i++) begin
			ps2_data = frame[i];
			hold(100);
			ps2_clk = 1'b0;
			hold(200);
			ps2_clk = 1'b1;
			hold(100);
		end
		hold(400);
	endtask

	task automatic build_table();
		ctrl_row(28'h0_00_00_00, 12'hFFF, 3'b001);
		video_row(5'b00000, 8'h00);
		key_row({SC_EXTENDED, SC_UP, 8'h00}, 2, 0, 12'hF7F);
		key_row({SC_EXTENDED, SC_RELEASE, SC_UP}, 3, 0, 12'hFFF);
		key_row({SC_EXTENDED, SC_DOWN, 8'h00}, 2, 0, 12'hFBF);
		key_row({SC_EXTENDED, SC_RELEASE, SC_DOWN}, 3, 0, 12'hFFF);
		key_row({SC_EXTENDED, SC_LEFT, 8'h00}, 2, 0, 12'hFDF);
		key_row({SC_EXTENDED, SC_RELEASE, SC_LEFT}, 3, 0, 12'hFFF);
		key_row({SC_EXTENDED, SC_RIGHT, 8'h00}, 2, 0, 12'hFEF);
		key_row({SC_EXTENDED, SC_RELEASE, SC_RIGHT}, 3, 0, 12'hFFF);
		key_row({SC_W, 16'h0}, 1, 0, 12'hFF7);
		key_row({SC_S, 16'h0}, 1, 0, 12'hFF3);
		key_row({SC_A, 16'h0}, 1, 0, 12'hFF1);
		key_row({SC_D, 16'h0}, 1, 0, 12'hFF0);
		key_row({SC_RELEASE, SC_W, 8'h00}, 2, 0, 12'hFF8);
		key_row({SC_RELEASE, SC_S, 8'h00}, 2, 0, 12'hFFC);
		key_row({SC_RELEASE, SC_A, 8'h00}, 2, 0, 12'hFFE);
		key_row({SC_RELEASE, SC_D, 8'h00}, 2, 0, 12'hFFF);
		key_row({SC_F1, 16'h0}, 1, 0, 12'hDFF);
		key_row({SC_RELEASE, SC_F1, 8'h00}, 2, 0, 12'hFFF);
		key_row({SC_F2, 16'h0}, 1, 0, 12'hEFF);
		key_row({SC_RELEASE, SC_F2, 8'h00}, 2, 0, 12'hFFF);
		key_row({SC_COIN, 16'h0}, 1, 0, 12'h3FF); // Both coin inputs.
		key_row({SC_RELEASE, SC_COIN, 8'h00}, 2, 0, 12'hFFF);
		key_row({SC_UP, 16'h0}, 1, 0, 12'hFFF); // Arrow code without E0.
		key_row({SC_W, 16'h0}, 1, 1, 12'hFFF); // Bad parity, no event.
		key_row({SC_W, 16'h0}, 1, 0, 12'hFF7);
		key_row({SC_RELEASE, SC_W, 8'h00}, 2, 0, 12'hFFF);
		key_row({SC_EXTENDED, SC_UP, 8'h00}, 2, 0, 12'hF7F);
		ctrl_row(28'h0_00_00_19, 12'hD6F, 3'b001); // Joystick ORed with the keyboard.
		ctrl_row(28'h0_00_16_00, 12'hE79, 3'b001);
		ctrl_row(28'h0_00_09_00, 12'hF76, 3'b001);
		key_row({SC_EXTENDED, SC_RELEASE, SC_UP}, 3, 0, 12'hFF6);
		ctrl_row(28'h0_00_00_00, 12'hFFF, 3'b001);
		ctrl_row(28'h0_01_00_00, 12'hFFF, 3'b101);
		ctrl_row(28'h0_40_00_00, 12'hFFF, 3'b101);
		ctrl_row(28'h2_00_00_00, 12'hFFF, 3'b101);
		ctrl_row(28'h0_02_00_00, 12'hFFF, 3'b011);
		ctrl_row(28'h4_00_00_00, 12'hFFF, 3'b000);
		ctrl_row(28'h8_00_00_00, 12'hFFF, 3'b000);
		ctrl_row(28'h0_00_00_00, 12'hFFF, 3'b001);
		audio_row(7'd0);
		audio_row(7'd1);
		audio_row(7'd64);
		audio_row(7'd127);
		video_row(5'b00001, 8'hFC); // {vb, hb, vs, hs, video}.
		video_row(5'b00011, 8'hFE);
		video_row(5'b00101, 8'hFD);
		video_row(5'b01001, 8'h00);
		video_row(5'b10001, 8'h00);
		video_row(5'b11110, 8'h03);
		video_row(5'b00111, 8'hFF);
	endtask

	initial begin
		#100_000_000;
		$display("Simulation stopped by the watchdog, the run took too long");
		$display("Test failed");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	initial begin
		row_t  r;
		int    n;
		int    exp_err;
		string what;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		joy0 = '0;
		joy1 = '0;
		status = '0;
		buttons = '0;
		lamp1 = 1'b0;
		lamp2 = 1'b0;
		audio = '0;
		video = 1'b0;
		hs = 1'b0;
		vs = 1'b0;
		hb = 1'b0;
		vb = 1'b0;
		exp_err = 0;
		n = 0;
		build_table();
		while (reset && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (reset) begin
			$display("Reset was never released");
			$display("Test failed");
			$finish;
		end else begin
			for (int i = 0; i < rows.size(); i++) begin
				r = rows[i];
				hold(1);
				case (r.kind)
					K_KEY: begin
						what = "key";
						for (int b = 0; b < r.n; b++)
							send_byte(r.seq[23 - 8 * b -: 8], r.bad);
						if (r.bad)
							exp_err++;
						chk0.expect_ctrl(r.exp, r.misc);
					end
					K_CTRL: begin
						what = "control";
						{lamp2, lamp1, buttons, status[7:0], joy1, joy0} = r.stim;
						hold(1); // Registered stage.
						chk0.expect_ctrl(r.exp, r.misc);
					end
					K_AUDIO: begin
						what = "audio";
						audio = r.stim[6:0];
						hold(4); // Flush the accumulator and output register.
						chk0.count_audio(r.exp);
					end
					default: begin
						what = "video";
						{vb, hb, vs, hs, video} = r.stim[4:0];
						@(posedge clk);
						chk0.expect_video(r.exp[7:0]);
					end
				endcase
				chk0.expect_errors(exp_err);
				chk0.end_row(i, what);
			end
			chk0.report();
			if (chk0.rows_failed == 0)
				$display("Test passed");
			else
				$display("Test failed");
			$finish;
		end
	end

endmodule

/* src.f */
arcade_pkg.sv
kbd_event_if.sv
ps2_receiver.sv
key_mapper.sv
control_merge.sv
sigma_delta_dac.sv
mono_video_out.sv
arcade_io_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_arcade_io.sv

/* Bender.yml */
package:
  name: arcade_io

sources:
  - arcade_pkg.sv
  - kbd_event_if.sv
  - ps2_receiver.sv
  - key_mapper.sv
  - control_merge.sv
  - sigma_delta_dac.sv
  - mono_video_out.sv
  - arcade_io_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_arcade_io.sv
